// File: icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address width in bits
`define ICACHE_ADDR_W 32

// 64-byte lines
`define ICACHE_OFFSET_W 6

// 128 lines, 8 KB in total
`define ICACHE_INDEX_W 7

// whatever is left of the address above index and offset
`define ICACHE_TAG_W 19

// 32-bit words per line, also the refill burst beat count
`define ICACHE_WORDS 16

// addresses below this go straight to memory and are never cached
`define ICACHE_UNCACHE_LIMIT 32'h8000_0000

`endif

// File: icache_pkg.sv
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

  // address fields, split as tag | index | offset
  typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
  typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;

  // word position inside a line (offset without the byte bits)
  typedef logic [$clog2(`ICACHE_WORDS)-1:0] word_sel_t;

  typedef logic [31:0] word_t;  // one instruction
  typedef logic [7:0]  burst_len_t;  // AXI ARLEN, beats minus one

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL_AR,
    REFILL_R,
    REREAD,
    UNC_AR,
    UNC_R
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: icache_array_if.sv
`default_nettype none

interface icache_array_if import icache_pkg::*; ();

  // lookup position and compare tag, driven by the controller
  index_t    rd_index;
  word_sel_t rd_word;
  tag_t      rd_tag;

  // refill writes, one word per R beat
  logic      fill_we;
  word_sel_t fill_word;
  word_t     fill_data;
  logic      tag_we;  // last beat, line becomes valid

  // array results
  logic      hit;
  word_t     rd_data;

  modport ctrl (
    output rd_index, rd_word, rd_tag,
    output fill_we, fill_word, fill_data, tag_we,
    input  hit, rd_data
  );

  modport tag (
    input  rd_index, rd_tag, tag_we,
    output hit
  );

  modport data (
    input  rd_index, rd_word, fill_we, fill_word, fill_data,
    output rd_data
  );

endinterface

`default_nettype wire

// File: icache_tag_array.sv
`default_nettype none

`include "icache_settings.svh"

module icache_tag_array import icache_pkg::*; (
  input logic clk,
  input logic rst,

  icache_array_if.tag arr
);

  localparam int LINES = 1 << `ICACHE_INDEX_W;

  logic [LINES-1:0] valid_q;
  tag_t             tag_mem [LINES];

  // lookup index, registered alongside the data array read
  index_t idx_q;

  logic   tag_match;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;  // whole cache empty
    end else if (arr.tag_we) begin
      valid_q[arr.rd_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (arr.tag_we) begin
      tag_mem[arr.rd_index] <= arr.rd_tag;
    end
  end

  always_ff @(posedge clk) begin
    idx_q <= arr.rd_index;
  end

  // compared against the tag of the captured request
  assign tag_match = (tag_mem[idx_q] == arr.rd_tag);
  assign arr.hit   = valid_q[idx_q] && tag_match;

endmodule

`default_nettype wire

// File: icache_data_array.sv
`default_nettype none

`include "icache_settings.svh"

module icache_data_array import icache_pkg::*; (
  input logic clk,

  icache_array_if.data arr
);

  localparam int LINES = 1 << `ICACHE_INDEX_W;
  localparam int WORDS = `ICACHE_WORDS;

  // one word per entry, written beat by beat during refill
  word_t mem [LINES][WORDS];

  word_t rd_data_q;

  always_ff @(posedge clk) begin
    if (arr.fill_we) begin
      mem[arr.rd_index][arr.fill_word] <= arr.fill_data;
    end
  end

  // synchronous read, result valid the cycle after the address
  always_ff @(posedge clk) begin
    rd_data_q <= mem[arr.rd_index][arr.rd_word];
  end

  assign arr.rd_data = rd_data_q;

endmodule

`default_nettype wire

// File: icache_ctrl.sv
`default_nettype none

`include "icache_settings.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // fetch side
  input  addr_t      fetch_addr_i,
  input  logic       fetch_valid_i,
  output logic       fetch_ready_o,
  output word_t      fetch_rdata_o,
  output logic       fetch_rdata_valid_o,

  // AXI4 read address channel
  output addr_t      m_axi_araddr_o,
  output burst_len_t m_axi_arlen_o,
  output logic       m_axi_arvalid_o,
  input  logic       m_axi_arready_i,

  // AXI4 read data channel
  input  word_t      m_axi_rdata_i,
  input  logic       m_axi_rvalid_i,
  input  logic       m_axi_rlast_i,
  output logic       m_axi_rready_o,

  icache_array_if.ctrl arr
);

  localparam int OFF_W = `ICACHE_OFFSET_W;
  localparam int IDX_W = `ICACHE_INDEX_W;

  // full line refill, beats minus one
  localparam burst_len_t REFILL_LEN = burst_len_t'(`ICACHE_WORDS - 1);
  localparam addr_t      UNC_LIMIT  = addr_t'(`ICACHE_UNCACHE_LIMIT);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  addr_t     req_addr_q;  // captured on acceptance
  word_sel_t beat_cnt_q;  // refill beat position
  word_t     unc_data_q;
  logic      unc_valid_q;

  // fields of the incoming and the captured address
  index_t    fetch_index;
  word_sel_t fetch_word;
  tag_t      req_tag;
  index_t    req_index;
  word_sel_t req_word;
  addr_t     line_addr;

  logic      uncached;
  logic      accept;
  logic      r_beat;
  logic      lookup_hit;

  assign fetch_index = fetch_addr_i[OFF_W +: IDX_W];
  assign fetch_word  = fetch_addr_i[OFF_W-1:2];
  assign req_tag     = req_addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign req_index   = req_addr_q[OFF_W +: IDX_W];
  assign req_word    = req_addr_q[OFF_W-1:2];
  assign line_addr   = {req_addr_q[`ICACHE_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

  // low region goes to memory directly
  assign uncached = (req_addr_q < UNC_LIMIT);

  assign accept = fetch_ready_o && fetch_valid_i;
  assign r_beat = m_axi_rvalid_i && m_axi_rready_o;

  // tag compare is valid only in LOOKUP, against the captured tag
  assign lookup_hit = (state_q == LOOKUP) && !uncached && arr.hit;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (fetch_valid_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (uncached) begin
          state_d = UNC_AR;
        end else if (!arr.hit) begin
          state_d = REFILL_AR;
        end else begin
          state_d = IDLE;
        end
      end
      REFILL_AR: begin
        if (m_axi_arready_i) begin
          state_d = REFILL_R;
        end
      end
      REFILL_R: begin
        if (r_beat && m_axi_rlast_i) begin
          state_d = REREAD;
        end
      end
      REREAD:  state_d = LOOKUP;  // one cycle for the registered data read
      UNC_AR: begin
        if (m_axi_arready_i) begin
          state_d = UNC_R;
        end
      end
      UNC_R: begin
        if (r_beat) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      beat_cnt_q  <= '0;
      unc_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      unc_valid_q <= (state_q == UNC_R) && r_beat;  // response one cycle after the beat
      if (state_q == REFILL_AR) begin
        beat_cnt_q <= '0;
      end else if ((state_q == REFILL_R) && r_beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // request and uncached payload
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr_q <= fetch_addr_i;
    end
    if ((state_q == UNC_R) && r_beat) begin
      unc_data_q <= m_axi_rdata_i;
    end
  end

  assign fetch_ready_o       = (state_q == IDLE);
  assign fetch_rdata_valid_o = lookup_hit || unc_valid_q;
  assign fetch_rdata_o       = unc_valid_q ? unc_data_q : arr.rd_data;

  // address and length hold while arvalid is high since req_addr_q does not move
  assign m_axi_arvalid_o = (state_q == REFILL_AR) || (state_q == UNC_AR);
  assign m_axi_araddr_o  = (state_q == UNC_AR) ? req_addr_q : line_addr;
  assign m_axi_arlen_o   = (state_q == UNC_AR) ? burst_len_t'(0) : REFILL_LEN;
  assign m_axi_rready_o  = (state_q == REFILL_R) || (state_q == UNC_R);

  // in IDLE the arrays see the incoming address so a hit answers next cycle
  assign arr.rd_index = fetch_ready_o ? fetch_index : req_index;
  assign arr.rd_word  = fetch_ready_o ? fetch_word : req_word;
  assign arr.rd_tag   = req_tag;

  assign arr.fill_we   = (state_q == REFILL_R) && r_beat;
  assign arr.fill_word = beat_cnt_q;
  assign arr.fill_data = m_axi_rdata_i;
  assign arr.tag_we    = arr.fill_we && m_axi_rlast_i;  // line complete

endmodule

`default_nettype wire

// File: icache_top.sv
`default_nettype none

module icache_top import icache_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // fetch unit
  input  addr_t      fetch_addr_i,
  input  logic       fetch_valid_i,
  output logic       fetch_ready_o,
  output word_t      fetch_rdata_o,
  output logic       fetch_rdata_valid_o,

  // AXI4 read master
  output addr_t      m_axi_araddr_o,
  output burst_len_t m_axi_arlen_o,
  output logic       m_axi_arvalid_o,
  input  logic       m_axi_arready_i,
  input  word_t      m_axi_rdata_i,
  input  logic       m_axi_rvalid_i,
  input  logic       m_axi_rlast_i,
  output logic       m_axi_rready_o
);

  // controller to tag and data arrays
  icache_array_if arr_if ();

  icache_ctrl u_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr_i),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_ready_o       (fetch_ready_o),
    .fetch_rdata_o       (fetch_rdata_o),
    .fetch_rdata_valid_o (fetch_rdata_valid_o),
    .m_axi_araddr_o      (m_axi_araddr_o),
    .m_axi_arlen_o       (m_axi_arlen_o),
    .m_axi_arvalid_o     (m_axi_arvalid_o),
    .m_axi_arready_i     (m_axi_arready_i),
    .m_axi_rdata_i       (m_axi_rdata_i),
    .m_axi_rvalid_i      (m_axi_rvalid_i),
    .m_axi_rlast_i       (m_axi_rlast_i),
    .m_axi_rready_o      (m_axi_rready_o),
    .arr                 (arr_if.ctrl)
  );

  icache_tag_array u_tag_array (
    .clk (clk),
    .rst (rst),
    .arr (arr_if.tag)
  );

  // 128 lines of 16 words, filled during refill
  icache_data_array u_data_array (
    .clk (clk),
    .arr (arr_if.data)
  );

endmodule

`default_nettype wire

// File: tb_icache_top.sv
`default_nettype none

`include "icache_settings.svh"

module tb_icache_top import icache_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int TIMEOUT_CYCLES = 4000;  // about 60 fetches of up to 60 cycles
  localparam int LINES        = 1 << `ICACHE_INDEX_W;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  addr_t      fetch_addr = '0;
  logic       fetch_valid = 1'b0;
  logic       fetch_ready;
  word_t      fetch_rdata;
  logic       fetch_rdata_valid;
  addr_t      araddr;
  burst_len_t arlen;
  logic       arvalid;
  logic       arready = 1'b0;
  word_t      rdata = '0;
  logic       rvalid = 1'b0;
  logic       rlast = 1'b0;
  logic       rready;

  integer seed = 765;
  logic   stall_en = 1'b0;  // random arready/rvalid gaps
  int     cycle_cnt = 0;
  int     err_cnt = 0;
  int     test_cnt = 0;
  int     test_fail_cnt = 0;

  // every AR seen by the memory model
  addr_t      ar_addr_log [$];
  burst_len_t ar_len_log [$];

  logic  rd_busy = 1'b0;
  addr_t beat_addr = '0;  // next beat to present
  int    beats_left = 0;

  // expected tag state of the cache
  logic shadow_valid [LINES];
  tag_t shadow_tag [LINES];

  icache_top dut (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr),
    .fetch_valid_i       (fetch_valid),
    .fetch_ready_o       (fetch_ready),
    .fetch_rdata_o       (fetch_rdata),
    .fetch_rdata_valid_o (fetch_rdata_valid),
    .m_axi_araddr_o      (araddr),
    .m_axi_arlen_o       (arlen),
    .m_axi_arvalid_o     (arvalid),
    .m_axi_arready_i     (arready),
    .m_axi_rdata_i       (rdata),
    .m_axi_rvalid_i      (rvalid),
    .m_axi_rlast_i       (rlast),
    .m_axi_rready_o      (rready)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a fetch never completed", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  // word address with its 16-bit halves swapped
  function automatic word_t mem_word(input addr_t a);
    addr_t w;
    w = {a[31:2], 2'b00};
    return {w[15:0], w[31:16]};
  endfunction

  // AXI read slave, INCR bursts of 4-byte beats
  always @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      rd_busy <= 1'b0;
    end else if (!rd_busy) begin
      if (arvalid && arready) begin
        $display("AR addr=%h len=%0d", araddr, arlen);
        ar_addr_log.push_back(araddr);
        ar_len_log.push_back(arlen);
        rd_busy    <= 1'b1;
        beat_addr  <= araddr;
        beats_left <= arlen + 1;
        arready    <= 1'b0;
      end else begin
        arready <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
      end
    end else if (rvalid && rready && rlast) begin
      rvalid  <= 1'b0;  // burst done
      rlast   <= 1'b0;
      rd_busy <= 1'b0;
    end else if (!rvalid || rready) begin
      if (beats_left != 0 && !(stall_en && (($random(seed) & 3) == 0))) begin
        rvalid     <= 1'b1;
        rdata      <= mem_word(beat_addr);
        rlast      <= (beats_left == 1);
        beat_addr  <= beat_addr + 4;
        beats_left <= beats_left - 1;
      end else begin
        rvalid <= 1'b0;
      end
    end
  end

  // called right after a rising edge, returns after the response and one idle check
  task automatic fetch(input addr_t a, output word_t data, output int lat);
    fetch_addr  <= a;
    fetch_valid <= 1'b1;
    @(posedge clk);
    while (!fetch_ready) @(posedge clk);
    fetch_valid <= 1'b0;  // accepted on this edge
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!fetch_rdata_valid);
    data = fetch_rdata;
    @(posedge clk);
    if (fetch_rdata_valid) begin
      $display("fetch at %h gave a second response pulse", a);
      err_cnt++;
    end
  endtask

  task automatic fetch_and_check(input addr_t a, output logic missed, output int lat);
    word_t      data;
    int         n_ar;
    logic       unc;
    logic       exp_ar;
    index_t     idx;
    tag_t       tg;
    addr_t      exp_addr;
    burst_len_t exp_len;
    unc      = (a < `ICACHE_UNCACHE_LIMIT);
    idx      = a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    tg       = a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    exp_ar   = unc || !shadow_valid[idx] || (shadow_tag[idx] != tg);
    exp_addr = unc ? a : {a[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
    exp_len  = unc ? 8'd0 : burst_len_t'(`ICACHE_WORDS - 1);
    n_ar     = ar_addr_log.size();
    fetch(a, data, lat);
    missed = (ar_addr_log.size() != n_ar);
    if (data !== mem_word(a)) begin
      $display("ERR fetch_rdata_o addr=%h got=%h exp=%h", a, data, mem_word(a));
      err_cnt++;
    end
    if (ar_addr_log.size() != n_ar + (exp_ar ? 1 : 0)) begin
      $display("fetch at %h issued %0d read bursts instead of %0d",
               a, ar_addr_log.size() - n_ar, exp_ar ? 1 : 0);
      err_cnt++;
    end else if (exp_ar) begin
      if (ar_addr_log[n_ar] !== exp_addr) begin
        $display("ERR m_axi_araddr_o got=%h exp=%h", ar_addr_log[n_ar], exp_addr);
        err_cnt++;
      end
      if (ar_len_log[n_ar] !== exp_len) begin
        $display("ERR m_axi_arlen_o got=%h exp=%h", ar_len_log[n_ar], exp_len);
        err_cnt++;
      end
    end
    if (!exp_ar && lat != 1) begin
      $display("hit at %h answered %0d cycles after acceptance instead of 1", a, lat);
      err_cnt++;
    end
    if (!unc) begin
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx]   = tg;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    test_cnt++;
    if (err_cnt == err_start) begin
      $display("test %s: ok", name);
    end else begin
      test_fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - err_start);
    end
  endtask

  task automatic test_reset_and_first_miss();
    int   err_start;
    logic missed;
    int   lat;
    err_start = err_cnt;
    if (fetch_ready !== 1'b1) begin
      $display("ERR fetch_ready_o got=%h exp=1", fetch_ready);
      err_cnt++;
    end
    if (arvalid !== 1'b0 || rready !== 1'b0 || fetch_rdata_valid !== 1'b0) begin
      $display("ERR arvalid/rready/rdata_valid got=%h%h%h exp=000",
               arvalid, rready, fetch_rdata_valid);
      err_cnt++;
    end
    fetch_and_check(32'h8000_0124, missed, lat);
    if (!missed) begin
      $display("first fetch of a cacheable line did not refill");
      err_cnt++;
    end
    finish_test("reset and first miss", err_start);
  endtask

  task automatic test_hit();
    int   err_start;
    logic missed;
    int   lat;
    err_start = err_cnt;
    fetch_and_check(32'h8000_0138, missed, lat);  // same line, word 14
    if (missed) begin
      $display("fetch of a filled line started a read burst");
      err_cnt++;
    end
    finish_test("hit", err_start);
  endtask

  task automatic test_uncached();
    int   err_start;
    logic missed;
    int   lat;
    err_start = err_cnt;
    repeat (2) begin
      fetch_and_check(32'h0000_1008, missed, lat);
      if (!missed) begin
        $display("uncached fetch was served without a memory read");
        err_cnt++;
      end
    end
    finish_test("uncached read", err_start);
  endtask

  task automatic test_conflict();
    int   err_start;
    logic missed;
    int   lat;
    err_start = err_cnt;
    fetch_and_check(32'h8000_2124, missed, lat);
    if (!missed) begin
      $display("conflicting tag at index 4 did not refill");
      err_cnt++;
    end
    fetch_and_check(32'h8000_0124, missed, lat);  // evicted, must miss again
    if (!missed) begin
      $display("evicted line still hit");
      err_cnt++;
    end
    finish_test("conflict eviction", err_start);
  endtask

  task automatic test_random_stalls();
    int          err_start;
    logic        missed;
    int          lat;
    logic [31:0] r;
    index_t      idx;
    addr_t       addr_list [40];
    err_start = err_cnt;
    for (int i = 0; i < 40; i++) begin  // whole address sequence up front
      r   = $random(seed);
      idx = 7'd4 + r[11:10];  // lines 4 to 7, two tags each
      if (r[0]) begin
        addr_list[i] = {20'h00001, 6'd0, r[7:4], 2'b00};
      end else begin
        addr_list[i] = {1'b1, 17'd0, r[12], idx, r[7:4], 2'b00};
      end
    end
    stall_en <= 1'b1;
    foreach (addr_list[i]) begin
      fetch_and_check(addr_list[i], missed, lat);
    end
    stall_en <= 1'b0;
    finish_test("random under stalls", err_start);
  endtask

  initial begin
    for (int i = 0; i < LINES; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_tag[i]   = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_reset_and_first_miss();
    test_hit();
    test_uncached();
    test_conflict();
    test_random_stalls();
    $display("%0d tests run, %0d with errors, %0d errors in total",
             test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: icache_top.f
+incdir+.
icache_pkg.sv
icache_array_if.sv
icache_tag_array.sv
icache_data_array.sv
icache_ctrl.sv
icache_top.sv
tb_icache_top.sv
